// ==== design/lsuPkg.sv ====
package lsuPkg;

    localparam int AddrW    = 32;
    localparam int DataW    = 32;
    localparam int TagW     = 4;             // Reorder nick width.
    localparam int MemWords = 256;
    localparam int IdxW     = $clog2(MemWords);
    localparam int WaitW    = 4;
    localparam int LaneW    = DataW / 8;     // Byte lanes per word.

    typedef enum logic [1:0] {
        AccByte = 2'd0,
        AccHalf = 2'd1,
        AccWord = 2'd2
    } accWidth_e;

    typedef struct packed {
        logic             isStore;
        logic             unsignedLd;
        accWidth_e        width;
        logic [AddrW-1:0] addr;
        logic [DataW-1:0] data;
        logic [TagW-1:0]  tag;
    } lsReq_t;

    typedef struct packed {
        logic             isStore;
        logic [IdxW-1:0]  wordIdx;
        logic [LaneW-1:0] byteEn;
        logic [DataW-1:0] wdata;       // Already shifted into its lanes.
    } memReq_t;

    typedef struct packed {
        logic [TagW-1:0] tag;
        logic [1:0]      offset;
        accWidth_e       width;
        logic            unsignedLd;
        logic            isStore;
        logic            fault;
    } opInfo_t;

    typedef struct packed {
        logic [TagW-1:0]  tag;
        logic [DataW-1:0] data;
        logic             fault;
    } lsResp_t;

endpackage

// ==== design/lsuDecode.sv ====
module lsuDecode import lsuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    reqEn,
    input  lsReq_t  req,
    input  logic    respEn,
    output logic    ready,
    output logic    decValid,
    output memReq_t decReq,
    output opInfo_t decInfo
);

    logic             busy;
    logic             accept;
    logic [1:0]       offset;
    logic             fault;
    logic [LaneW-1:0] laneMask;
    memReq_t          nextReq;
    opInfo_t          nextInfo;

    assign ready  = !busy;
    assign accept = reqEn && ready;
    assign offset = req.addr[1:0];

    always_comb begin
        case (req.width)
            AccByte: begin
                fault    = 1'b0;
                laneMask = 4'b0001;
            end
            AccHalf: begin
                fault    = offset[0];          // Odd half address.
                laneMask = 4'b0011;
            end
            default: begin
                fault    = (offset != 2'd0);
                laneMask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        nextReq.isStore = req.isStore;
        nextReq.wordIdx = req.addr[IdxW+1:2];  // Wraps modulo MemWords.
        nextReq.byteEn  = fault ? '0 : (laneMask << offset);
        nextReq.wdata   = req.data << {offset, 3'b000};

        nextInfo.tag        = req.tag;
        nextInfo.offset     = offset;
        nextInfo.width      = req.width;
        nextInfo.unsignedLd = req.unsignedLd;
        nextInfo.isStore    = req.isStore;
        nextInfo.fault      = fault;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            decValid <= 1'b0;
        end else begin
            decValid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (respEn) begin
                busy <= 1'b0;                  // Ready again next cycle.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decReq  <= nextReq;
            decInfo <= nextInfo;
        end
    end

endmodule

// ==== design/memPort.sv ====
module memPort import lsuPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             decValid,
    input  memReq_t          decReq,
    input  opInfo_t          decInfo,
    output logic             memEn,
    output memReq_t          memReq,
    input  logic             memDone,
    input  logic [DataW-1:0] memRdata,
    output logic             rawValid,
    output logic [DataW-1:0] rawData,
    output opInfo_t          rawInfo
);

    logic    occupied;
    logic    faultPend;
    logic    take;
    opInfo_t info;

    assign take    = decValid && !occupied;
    assign rawInfo = info;             // Stable until the next op.

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            faultPend <= 1'b0;
            memEn     <= 1'b0;
            rawValid  <= 1'b0;
        end else begin
            memEn    <= 1'b0;
            rawValid <= 1'b0;
            if (take) begin
                occupied  <= 1'b1;
                faultPend <= decInfo.fault;
                memEn     <= !decInfo.fault;
            end else if (faultPend) begin
                // Misaligned op never reaches the controller.
                faultPend <= 1'b0;
                occupied  <= 1'b0;
                rawValid  <= 1'b1;
            end else if (memDone && occupied) begin
                occupied <= 1'b0;
                rawValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            info   <= decInfo;
            memReq <= decReq;
        end
        if (faultPend) begin
            rawData <= '0;
        end else if (memDone) begin
            rawData <= memRdata;
        end
    end

endmodule

// ==== design/memCtrl.sv ====
module memCtrl import lsuPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             memEn,
    input  memReq_t          memReq,
    input  logic [WaitW-1:0] memWait,
    output logic             memDone,
    output logic [DataW-1:0] memRdata
);

    logic [DataW-1:0] ram [MemWords];
    logic [WaitW-1:0] cnt;
    logic [WaitW-1:0] curCnt;
    logic             running;
    logic             active;
    logic             fire;
    memReq_t          held;
    memReq_t          curReq;

    // A new enable counts from memWait in the same cycle.
    assign active = memEn || running;
    assign curCnt = memEn ? memWait : cnt;
    assign curReq = memEn ? memReq : held;
    assign fire   = active && (curCnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            cnt     <= '0;
            memDone <= 1'b0;
        end else begin
            memDone <= fire;
            if (fire) begin
                running <= 1'b0;
            end else if (active) begin
                running <= 1'b1;
                cnt     <= curCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memEn) begin
            held <= memReq;
        end
        if (fire) begin
            memRdata <= ram[curReq.wordIdx];   // Old word on a store.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MemWords; i++) begin
                ram[i] <= '0;
            end
        end else if (fire && curReq.isStore) begin
            for (int b = 0; b < LaneW; b++) begin
                if (curReq.byteEn[b]) begin
                    ram[curReq.wordIdx][8*b +: 8] <= curReq.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== design/lsuResult.sv ====
module lsuResult import lsuPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             rawValid,
    input  logic [DataW-1:0] rawData,
    input  opInfo_t          rawInfo,
    output logic             respEn,
    output lsResp_t          resp
);

    logic [DataW-1:0] shifted;
    logic [DataW-1:0] extended;
    lsResp_t          nextResp;

    assign shifted = rawData >> {rawInfo.offset, 3'b000};

    always_comb begin
        case (rawInfo.width)
            AccByte: begin
                if (rawInfo.unsignedLd) begin
                    extended = {{(DataW-8){1'b0}}, shifted[7:0]};
                end else begin
                    extended = {{(DataW-8){shifted[7]}}, shifted[7:0]};
                end
            end
            AccHalf: begin
                if (rawInfo.unsignedLd) begin
                    extended = {{(DataW-16){1'b0}}, shifted[15:0]};
                end else begin
                    extended = {{(DataW-16){shifted[15]}}, shifted[15:0]};
                end
            end
            default: extended = shifted;
        endcase
    end

    always_comb begin
        nextResp.tag   = rawInfo.tag;
        nextResp.fault = rawInfo.fault;
        // Stores and faults carry no data.
        nextResp.data  = (rawInfo.isStore || rawInfo.fault) ? '0 : extended;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            respEn <= 1'b0;
        end else begin
            respEn <= rawValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rawValid) begin
            resp <= nextResp;
        end
    end

endmodule

// ==== design/lsuTop.sv ====
module lsuTop import lsuPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             reqEn,
    input  lsReq_t           req,
    input  logic [WaitW-1:0] memWait,
    output logic             ready,
    output logic             respEn,
    output lsResp_t          resp
);

    logic             decValid;
    memReq_t          decReq;
    opInfo_t          decInfo;
    logic             memEn;
    memReq_t          memReq;
    logic             memDone;
    logic [DataW-1:0] memRdata;
    logic             rawValid;
    logic [DataW-1:0] rawData;
    opInfo_t          rawInfo;

    lsuDecode decode0 (
        .clk      (clk),
        .rst      (rst),
        .reqEn    (reqEn),
        .req      (req),
        .respEn   (respEn),
        .ready    (ready),
        .decValid (decValid),
        .decReq   (decReq),
        .decInfo  (decInfo)
    );

    memPort port0 (
        .clk      (clk),
        .rst      (rst),
        .decValid (decValid),
        .decReq   (decReq),
        .decInfo  (decInfo),
        .memEn    (memEn),
        .memReq   (memReq),
        .memDone  (memDone),
        .memRdata (memRdata),
        .rawValid (rawValid),
        .rawData  (rawData),
        .rawInfo  (rawInfo)
    );

    memCtrl ctrl0 (
        .clk      (clk),
        .rst      (rst),
        .memEn    (memEn),
        .memReq   (memReq),
        .memWait  (memWait),
        .memDone  (memDone),
        .memRdata (memRdata)
    );

    lsuResult result0 (
        .clk      (clk),
        .rst      (rst),
        .rawValid (rawValid),
        .rawData  (rawData),
        .rawInfo  (rawInfo),
        .respEn   (respEn),
        .resp     (resp)
    );

endmodule

// ==== dv/lsuChecker.sv ====
module lsuChecker import lsuPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             reqEn,
    input  lsReq_t           req,
    input  logic [WaitW-1:0] memWait,
    input  logic             ready,
    input  logic             respEn,
    input  lsResp_t          resp,
    output int               errCount
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] model [MemWords*LaneW];     // Byte view of the RAM.
    logic       pending;
    logic       readyDue;
    lsResp_t    expResp;
    int         expLat;
    int         acceptCycle;
    int         cycle;
    int         opCount = 0;
    string      opName;

    initial begin
        errCount = 0;
        for (int i = 0; i < MemWords*LaneW; i++) begin
            model[i] = 8'h00;
        end
    end

    task automatic reportError(input string msg);
        errCount++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic compareValue(input string what, input logic [DataW-1:0] expVal,
                                input logic [DataW-1:0] actVal);
        if (actVal !== expVal) begin
            errCount++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", opName, what, expVal, actVal);
        end
    endtask

    function automatic logic [DataW-1:0] loadValue(input int a, input accWidth_e w,
                                                   input logic uns);
        logic [15:0] half;
        half = {model[a+1], model[a]};
        case (w)
            AccByte: return uns ? {{(DataW-8){1'b0}}, model[a]} : {{(DataW-8){model[a][7]}}, model[a]};
            AccHalf: return uns ? {{(DataW-16){1'b0}}, half} : {{(DataW-16){half[15]}}, half};
            default: return {model[a+3], model[a+2], half};
        endcase
    endfunction

    task automatic storeBytes(input int a, input accWidth_e w, input logic [DataW-1:0] d);
        int n;
        n = (w == AccByte) ? 1 : (w == AccHalf) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            model[a + b] = d[8*b +: 8];
        end
    endtask

    always @(posedge clk) begin : watch
        int   a;
        logic fault;
        if (rst) begin
            pending  = 1'b0;
            readyDue = 1'b1;                // Ready must be high right after reset.
            cycle    = 0;
        end else begin
            cycle++;
            if (readyDue && !ready) begin
                reportError("ready is low right after reset or after a done pulse");
            end
            readyDue = 1'b0;
            if (pending && ready) begin
                reportError($sformatf("ready is high while %s is in flight", opName));
            end
            if (respEn) begin
                if (!pending) begin
                    reportError("done pulse arrived with no request pending");
                end else begin
                    if (cycle - acceptCycle != expLat) begin
                        reportError($sformatf("%s took %0d cycles, expected %0d",
                                              opName, cycle - acceptCycle, expLat));
                    end
                    compareValue("tag", expResp.tag, resp.tag);
                    compareValue("data", expResp.data, resp.data);
                    compareValue("fault", expResp.fault, resp.fault);
                    pending = 1'b0;
                end
                readyDue = 1'b1;
            end
            if (reqEn && ready) begin
                if (pending) begin
                    reportError("a second request was accepted while one was in flight");
                end else begin
                    a     = int'(req.addr[IdxW+1:0]);  // Wraps with the RAM depth.
                    fault = (req.width == AccHalf && req.addr[0]) ||
                            (req.width == AccWord && req.addr[1:0] != 2'd0);
                    opName = $sformatf("op%0d %s w%0d addr %h", opCount,
                                       req.isStore ? "store" : "load", req.width, req.addr);
                    opCount++;
                    expResp.tag   = req.tag;
                    expResp.fault = fault;
                    expResp.data  = (fault || req.isStore) ? '0 :
                                    loadValue(a, req.width, req.unsignedLd);
                    expLat        = fault ? 4 : int'(memWait) + 5;
                    if (!fault && req.isStore) begin
                        storeBytes(a, req.width, req.data);
                    end
                    acceptCycle = cycle;
                    pending     = 1'b1;
                end
            end
        end
    end

endmodule

// ==== dv/lsuTb.sv ====
module lsuTb import lsuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumOps      = 400;
    localparam int ResetCycles = 16;
    localparam int MaxWait     = 15;
    localparam int MaxIdle     = 3;
    localparam int CycleLimit  = NumOps * (MaxWait + 8 + MaxIdle) + ResetCycles + 100;

    logic             clk;
    logic             rst;
    logic             reqEn;
    lsReq_t           req;
    logic [WaitW-1:0] memWait;
    logic             ready;
    logic             respEn;
    lsResp_t          resp;
    int               checkErrors;
    int               cycles = 0;
    logic [31:0]      seed;
    logic [AddrW-1:0] lastAddr;

    always #20 clk = ~clk;                  // 40 ns period.

    lsuTop dut0 (
        .clk     (clk),
        .rst     (rst),
        .reqEn   (reqEn),
        .req     (req),
        .memWait (memWait),
        .ready   (ready),
        .respEn  (respEn),
        .resp    (resp)
    );

    lsuChecker checker0 (
        .clk      (clk),
        .rst      (rst),
        .reqEn    (reqEn),
        .req      (req),
        .memWait  (memWait),
        .ready    (ready),
        .respEn   (respEn),
        .resp     (resp),
        .errCount (checkErrors)
    );

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};   // Strong high bits land low.
    endfunction

    task automatic buildRequest(input int opNum, output lsReq_t r,
                                output logic [WaitW-1:0] w);
        logic [31:0] a;
        logic [31:0] b;
        a            = nextRand();
        b            = nextRand();
        r.isStore    = a[0];
        r.unsignedLd = a[1];
        case (a[3:2])
            2'd0:    r.width = AccByte;
            2'd1:    r.width = AccHalf;
            default: r.width = AccWord;
        endcase
        if (a[5:4] == 2'd0) begin
            r.addr = lastAddr;              // Revisit the previous location.
        end else begin
            r.addr = {b[31:10], 4'b0000, b[5:0]};
        end
        if (a[8:6] != 3'd0 || opNum <= MaxWait) begin
            if (r.width == AccHalf) r.addr[0] = 1'b0;
            if (r.width == AccWord) r.addr[1:0] = 2'b00;
        end
        r.data = nextRand();
        r.tag  = a[15:12];
        // First ops sweep every wait value.
        w = (opNum <= MaxWait) ? opNum[WaitW-1:0] : b[9:6];
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: no progress within %0d cycles, %0d errors counted",
                     CycleLimit, checkErrors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        lsReq_t           nextReq;
        logic [WaitW-1:0] nextWait;
        int               idle;
        clk      = 1'b0;
        rst      = 1'b1;
        reqEn    = 1'b0;
        req      = '0;
        memWait  = '0;
        seed     = 32'h9ab8_ead4;
        lastAddr = '0;
        repeat (ResetCycles) @(posedge clk);
        #2 rst = 1'b0;
        for (int i = 0; i < NumOps; i++) begin
            buildRequest(i, nextReq, nextWait);
            idle = int'(nextRand() & 32'd3);
            repeat (idle) @(posedge clk);
            do begin
                @(posedge clk);
                #2;
            end while (!ready);
            reqEn    = 1'b1;
            req      = nextReq;
            memWait  = nextWait;            // Only moves while ready is high.
            lastAddr = nextReq.addr;
            @(posedge clk);
            #2 reqEn = 1'b0;
        end
        do begin
            @(posedge clk);
            #2;
        end while (!ready);
        repeat (2) @(posedge clk);
        $display("Summary: %0d ops issued, %0d errors", NumOps, checkErrors);
        if (checkErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== lsuTop.f ====
design/lsuPkg.sv
design/lsuDecode.sv
design/memPort.sv
design/memCtrl.sv
design/lsuResult.sv
design/lsuTop.sv
dv/lsuChecker.sv
dv/lsuTb.sv
